/* dcore_rx_top.f */
design/dcore_pkg.sv
design/rx_bit_path.sv
design/prbs_gen.sv
design/prbs_checker.sv
design/pi_ctl_scaler.sv
design/dcore_rx_top.sv
bench/dcore_rx_monitor.sv
bench/dcore_rx_tb.sv

/* bench/dcore_rx_tb.sv */
`timescale 1ns/1ps

module dcore_rx_tb;

    localparam int N_COUNT = 32;
    localparam int N_ROWS  = 6;
    localparam int FRZ_LEN = 4;

    // one test row with injection offset 0 meaning none
    typedef struct packed {
        logic        bist;
        logic [31:0] eqn;
        logic [15:0] chan_sel;
        logic [15:0] align_len;
        logic [15:0] count_len;
        logic [15:0] inj0;
        logic [15:0] inj1;
        logic [8:0]  pi_ctl;
        logic [4:0]  max_sel;
        logic [8:0]  offset;
        logic        bypass_en;
        logic [8:0]  bypass_code;
        logic [8:0]  pi_exp;
    } row_t;

    logic                                         clk_adc = 1'b0;
    logic                                         reset_i;
    dcore_pkg::adc_codes_t                        adc_codes_i;
    logic signed [dcore_pkg::N_ADC-1:0]           adc_thresh_i;
    logic                                         sel_bist_i;
    dcore_pkg::prbs_gen_cfg_t                     gen_cfg_i;
    dcore_pkg::prbs_chk_cfg_t                     chk_cfg_i;
    dcore_pkg::pi_codes_t                         pi_ctl_i;
    dcore_pkg::pi_ch_cfg_t [dcore_pkg::N_OUT-1:0] pi_cfg_i;
    logic [N_COUNT-1:0]                           err_bits_o;
    logic [N_COUNT-1:0]                           total_bits_o;
    dcore_pkg::pi_codes_t                         pi_ctl_o;
    logic [dcore_pkg::N_TI-1:0]                   flip_mask_i;
    logic                                         check_i;
    logic [dcore_pkg::N_PI-1:0]                   pi_exp_i;
    int                                           pi_errs_o;
    int                                           cnt_errs_o;

    row_t        rows [N_ROWS];
    logic [31:0] seed = 32'h6ef6db13;
    logic [31:0] chan_lfsr [dcore_pkg::N_TI];
    int          cycles = 0;
    int          limit = 55;

    initial begin
        forever #5 clk_adc = ~clk_adc;
    end

    dcore_rx_top #(.N_COUNT(N_COUNT)) dcore_rx_top_i (.*);

    dcore_rx_monitor #(.N_COUNT(N_COUNT)) dcore_rx_monitor_i (
        .*,
        .err_bits_i   (err_bits_o),
        .total_bits_i (total_bits_o),
        .pi_out_i     (pi_ctl_o)
    );

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // codes follow each channel's PRBS model and one channel may land on the wrong side
    task automatic drive_cycle(input int flip_ch);
        logic b;
        int   mag;
        int   code;
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            b            = ^(chan_lfsr[k] & chk_cfg_i.eqn);
            chan_lfsr[k] = {chan_lfsr[k][30:0], b};
            b            = b ^ (k == flip_ch);
            mag          = int'(next_random() >> 16);
            if (b) begin
                code = adc_thresh_i + mag % (128 - adc_thresh_i);
            end else begin
                code = adc_thresh_i - 1 - mag % (adc_thresh_i + 128);
            end
            adc_codes_i[k] = code[7:0];
        end
        @(negedge clk_adc);
    endtask

    task automatic run_row(input row_t row);
        int   flip_ch;
        logic hit;
        flip_ch = -1;
        for (int k = dcore_pkg::N_TI - 1; k >= 0; k--) begin
            if (row.chan_sel[k]) flip_ch = k;
        end
        sel_bist_i         = row.bist;
        gen_cfg_i.eqn      = row.eqn;
        chk_cfg_i.eqn      = row.eqn;
        chk_cfg_i.chan_sel = row.chan_sel;
        chk_cfg_i.mode     = dcore_pkg::CHK_ALIGN;
        for (int j = 0; j < dcore_pkg::N_OUT; j++) begin
            pi_ctl_i[j] = row.pi_ctl;
            pi_cfg_i[j] = '{row.max_sel, row.offset, row.bypass_en, row.bypass_code};
        end
        pi_exp_i = row.pi_exp;
        repeat (row.align_len) drive_cycle(-1);
        chk_cfg_i.mode = dcore_pkg::CHK_COUNT;
        for (int c = 0; c < row.count_len; c++) begin
            hit               = (c != 0) && (c == row.inj0 || c == row.inj1);
            gen_cfg_i.inj_err = hit && row.bist;
            flip_mask_i       = !hit ? '0 : (row.bist ? '1 : 16'd1 << flip_ch);
            drive_cycle((hit && !row.bist) ? flip_ch : -1);
        end
        gen_cfg_i.inj_err = 1'b0;
        flip_mask_i       = '0;
        chk_cfg_i.mode    = dcore_pkg::CHK_FREEZE;
        drive_cycle(-1);
        check_i = 1'b1;
        drive_cycle(-1);
        check_i = 1'b0;
        repeat (FRZ_LEN - 2) drive_cycle(-1);
    endtask

    initial begin
        reset_i      = 1'b1;
        adc_codes_i  = '0;
        adc_thresh_i = 8'sd5;
        sel_bist_i   = 1'b0;
        gen_cfg_i    = '{cke: 1'b1, eqn: 32'h60, init: 32'h0000_00a5, inj_err: 1'b0};
        chk_cfg_i    = '{cke: 1'b1, eqn: 32'h60, chan_sel: '0, mode: dcore_pkg::CHK_ALIGN};
        pi_ctl_i     = '0;
        pi_cfg_i     = '0;
        flip_mask_i  = '0;
        check_i      = 1'b0;
        pi_exp_i     = '0;
        // src, eqn, chan_sel, align, count, inj0, inj1 / ctl, max_sel, offset, bypass, code, exp
        rows[0] = '{1'b1, 32'h0000_0060, 16'hffff, 40, 100, 0, 0,
                    9'd100, 5'd31, 9'd0, 1'b0, 9'h000, 9'h063};
        rows[1] = '{1'b1, 32'h4800_0000, 16'hffff, 48, 200, 20, 80,
                    9'd300, 5'd15, 9'd20, 1'b0, 9'h000, 9'h09f};
        rows[2] = '{1'b1, 32'h0000_d008, 16'h00f3, 40, 150, 30, 0,
                    9'd500, 5'd7, 9'd100, 1'b0, 9'h000, 9'h015};
        rows[3] = '{1'b0, 32'h0000_0110, 16'hffff, 40, 120, 25, 0,
                    9'd77, 5'd3, 9'd5, 1'b1, 9'h1a5, 9'h1a5};
        rows[4] = '{1'b0, 32'h0000_d008, 16'h0a50, 40, 100, 40, 0,
                    9'd511, 5'd0, 9'd0, 1'b0, 9'h000, 9'h00e};
        rows[5] = '{1'b0, 32'h0000_6000, 16'h8001, 40, 80, 10, 0,
                    9'd256, 5'd20, 9'd511, 1'b0, 9'h000, 9'h0a6};
        foreach (rows[r]) begin
            limit += rows[r].align_len + rows[r].count_len + FRZ_LEN;
        end
        foreach (chan_lfsr[k]) begin
            chan_lfsr[k] = next_random();
        end
        repeat (5) @(negedge clk_adc);
        reset_i = 1'b0;
        foreach (rows[r]) begin
            run_row(rows[r]);
        end
        // the monitor compares on the last falling edge too
        @(posedge clk_adc);
        $display("checks done, pi errors %0d, counter errors %0d", pi_errs_o, cnt_errs_o);
        if (pi_errs_o + cnt_errs_o == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // cycle limit from the row lengths
    always @(posedge clk_adc) begin
        cycles++;
        if (cycles > limit) begin
            $display("run did not finish within %0d cycles", limit);
            $display("tests failed");
            $finish;
        end
    end

endmodule

/* bench/dcore_rx_monitor.sv */
`timescale 1ns/1ps

module dcore_rx_monitor #(
    parameter int N_COUNT = 32
) (
    input  logic                                         clk_adc,
    input  logic                                         reset_i,
    input  dcore_pkg::prbs_chk_cfg_t                     chk_cfg_i,
    input  dcore_pkg::pi_codes_t                         pi_ctl_i,
    input  dcore_pkg::pi_ch_cfg_t [dcore_pkg::N_OUT-1:0] pi_cfg_i,
    input  logic [N_COUNT-1:0]                           err_bits_i,
    input  logic [N_COUNT-1:0]                           total_bits_i,
    input  dcore_pkg::pi_codes_t                         pi_out_i,
    input  logic [dcore_pkg::N_TI-1:0]                   flip_mask_i,
    input  logic                                         check_i,
    input  logic [dcore_pkg::N_PI-1:0]                   pi_exp_i,
    output int                                           pi_errs_o,
    output int                                           cnt_errs_o
);

    // predictions for the outputs after the last rising edge
    dcore_pkg::pi_codes_t       pi_model;
    logic [dcore_pkg::N_PI-1:0] pi_table;
    logic [N_COUNT-1:0]         total_exp;
    logic [N_COUNT-1:0]         err_exp;
    logic                       err_known = 1'b0;
    int                         bad_sum = 0;
    int                         pi_errs = 0;
    int                         cnt_errs = 0;

    assign pi_errs_o  = pi_errs;
    assign cnt_errs_o = cnt_errs;

    function automatic int ones(input logic [31:0] v);
        int n;
        n = 0;
        for (int k = 0; k < 32; k++) begin
            n += v[k];
        end
        return n;
    endfunction

    // scale grows by 16 per max_sel step, offset wraps at 2^N_PI
    function automatic logic [dcore_pkg::N_PI-1:0] pi_rule(
        input logic [dcore_pkg::N_PI-1:0] ctl,
        input dcore_pkg::pi_ch_cfg_t      c
    );
        int scale;
        int code;
        int prod;
        scale = 16 * (c.max_sel + 1) - 1;
        code  = (ctl + c.offset) % (1 << dcore_pkg::N_PI);
        prod  = code * scale;
        if (c.bypass_en) begin
            return c.bypass_code;
        end
        return prod[2*dcore_pkg::N_PI-1:dcore_pkg::N_PI];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model, follows the inputs at each rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_adc) begin
        for (int j = 0; j < dcore_pkg::N_OUT; j++) begin
            pi_model[j] = reset_i ? '0 : pi_rule(pi_ctl_i[j], pi_cfg_i[j]);
        end
        pi_table = reset_i ? '0 : pi_exp_i;
        if (reset_i || (chk_cfg_i.cke && chk_cfg_i.mode == dcore_pkg::CHK_ALIGN)) begin
            total_exp = '0;
            err_exp   = '0;
            err_known = 1'b1;
            bad_sum   = 0;
        end else if (chk_cfg_i.cke && chk_cfg_i.mode == dcore_pkg::CHK_COUNT) begin
            total_exp = total_exp + ones(chk_cfg_i.chan_sel);
            err_known = 1'b0;
            bad_sum   = bad_sum + ones(flip_mask_i & chk_cfg_i.chan_sel);
        end
        // a flipped bit misses once itself and once more per tap
        if (check_i) begin
            err_exp   = bad_sum * (1 + ones(chk_cfg_i.eqn));
            err_known = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare on the falling edge, outputs are settled
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_adc) begin
        for (int j = 0; j < dcore_pkg::N_OUT; j++) begin
            if (pi_out_i[j] !== pi_model[j] || pi_out_i[j] !== pi_table) begin
                $display("** Error pi_ctl_o[%0d]: expected %h, table %h, actual %h",
                         j, pi_model[j], pi_table, pi_out_i[j]);
                pi_errs++;
            end
        end
        if (total_bits_i !== total_exp) begin
            $display("** Error total_bits_o: expected %h, actual %h", total_exp, total_bits_i);
            cnt_errs++;
        end
        if (err_known && err_bits_i !== err_exp) begin
            $display("** Error err_bits_o: expected %h, actual %h", err_exp, err_bits_i);
            cnt_errs++;
        end
    end

endmodule

/* design/dcore_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcore_rx_top #(
    parameter int N_COUNT = 32
) (
    input  wire logic                                         clk_adc,
    input  wire logic                                         reset_i,

    // ADC side
    input  wire dcore_pkg::adc_codes_t                        adc_codes_i,
    input  wire logic signed [dcore_pkg::N_ADC-1:0]           adc_thresh_i,
    input  wire logic                                         sel_bist_i,

    // PRBS configuration
    input  wire dcore_pkg::prbs_gen_cfg_t                     gen_cfg_i,
    input  wire dcore_pkg::prbs_chk_cfg_t                     chk_cfg_i,

    // PI control
    input  wire dcore_pkg::pi_codes_t                         pi_ctl_i,
    input  wire dcore_pkg::pi_ch_cfg_t [dcore_pkg::N_OUT-1:0] pi_cfg_i,

    output wire logic [N_COUNT-1:0]                           err_bits_o,
    output wire logic [N_COUNT-1:0]                           total_bits_o,
    output dcore_pkg::pi_codes_t                              pi_ctl_o
);

    logic                bist_bit;
    dcore_pkg::rx_bits_t rx_bits;

    //////////////////////////////////////////////////////////////////////
    // bit checking path
    //////////////////////////////////////////////////////////////////////

    // BIST source
    prbs_gen prbs_gen_i (
        .clk_adc (clk_adc),
        .reset_i (reset_i),
        .cfg_i   (gen_cfg_i),
        .bit_o   (bist_bit)
    );

    // slicer and source mux
    rx_bit_path rx_bit_path_i (
        .clk_adc    (clk_adc),
        .reset_i    (reset_i),
        .codes_i    (adc_codes_i),
        .thresh_i   (adc_thresh_i),
        .sel_bist_i (sel_bist_i),
        .bist_bit_i (bist_bit),
        .rx_bits_o  (rx_bits)
    );

    prbs_checker #(
        .N_COUNT (N_COUNT)
    ) prbs_checker_i (
        .clk_adc      (clk_adc),
        .reset_i      (reset_i),
        .cfg_i        (chk_cfg_i),
        .rx_bits_i    (rx_bits),
        .err_bits_o   (err_bits_o),
        .total_bits_o (total_bits_o)
    );

    //////////////////////////////////////////////////////////////////////
    // PI control codes
    //////////////////////////////////////////////////////////////////////

    pi_ctl_scaler pi_ctl_scaler_i (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .pi_ctl_i (pi_ctl_i),
        .cfg_i    (pi_cfg_i),
        .pi_ctl_o (pi_ctl_o)
    );

endmodule

`default_nettype wire

/* design/pi_ctl_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_ctl_scaler (
    input  wire logic                                         clk_adc,
    input  wire logic                                         reset_i,
    input  wire dcore_pkg::pi_codes_t                         pi_ctl_i,
    input  wire dcore_pkg::pi_ch_cfg_t [dcore_pkg::N_OUT-1:0] cfg_i,
    output dcore_pkg::pi_codes_t                              pi_ctl_o
);

    dcore_pkg::pi_codes_t pi_next;

    //////////////////////////////////////////////////////////////////////
    // per output arithmetic
    //////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < dcore_pkg::N_OUT; j++) begin : g_out
        logic [dcore_pkg::N_PI-1:0]   scale;
        logic [dcore_pkg::N_PI-1:0]   unscaled;
        logic [2*dcore_pkg::N_PI-1:0] product;

        // full scale at max_sel 31 is 511
        assign scale    = ((cfg_i[j].max_sel + 1'b1) << 4) - 1'b1;

        // offset wraps modulo 2^N_PI
        assign unscaled = pi_ctl_i[j] + cfg_i[j].offset;

        assign product  = unscaled * scale;

        // keep the upper half of the product
        assign pi_next[j] = cfg_i[j].bypass_en ? cfg_i[j].bypass_code :
                                                 product[2*dcore_pkg::N_PI-1:dcore_pkg::N_PI];
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            pi_ctl_o <= '0;
        end else begin
            pi_ctl_o <= pi_next;
        end
    end

endmodule

`default_nettype wire

/* design/prbs_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module prbs_checker #(
    parameter int N_COUNT = 32
) (
    input  wire logic                     clk_adc,
    input  wire logic                     reset_i,
    input  wire dcore_pkg::prbs_chk_cfg_t cfg_i,
    input  wire dcore_pkg::rx_bits_t      rx_bits_i,
    output logic [N_COUNT-1:0]            err_bits_o,
    output logic [N_COUNT-1:0]            total_bits_o
);

    // received history per channel
    logic [dcore_pkg::N_TI-1:0][dcore_pkg::N_PRBS-1:0] hist;
    logic [dcore_pkg::N_TI-1:0][dcore_pkg::N_PRBS-1:0] hist_next;

    dcore_pkg::rx_bits_t pred;
    dcore_pkg::rx_bits_t mismatch;

    logic [N_COUNT-1:0] err_inc;
    logic [N_COUNT-1:0] tot_inc;

    //////////////////////////////////////////////////////////////////////
    // prediction
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            pred[k]      = ^(hist[k] & cfg_i.eqn);
            hist_next[k] = {hist[k][dcore_pkg::N_PRBS-2:0], rx_bits_i[k]};
        end
    end

    // only selected channels can flag an error
    assign mismatch = (pred ^ rx_bits_i) & cfg_i.chan_sel;

    // popcounts for this cycle
    always_comb begin
        err_inc = '0;
        tot_inc = '0;
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            err_inc = err_inc + N_COUNT'(mismatch[k]);
            tot_inc = tot_inc + N_COUNT'(cfg_i.chan_sel[k]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // history and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            hist         <= '0;
            err_bits_o   <= '0;
            total_bits_o <= '0;
        end else if (cfg_i.cke) begin
            case (cfg_i.mode)
                dcore_pkg::CHK_ALIGN: begin
                    // lock onto the incoming sequence
                    hist         <= hist_next;
                    err_bits_o   <= '0;
                    total_bits_o <= '0;
                end
                dcore_pkg::CHK_COUNT: begin
                    hist         <= hist_next;
                    err_bits_o   <= err_bits_o + err_inc;
                    total_bits_o <= total_bits_o + tot_inc;
                end
                default: begin
                    // freeze, everything holds
                    hist         <= hist;
                    err_bits_o   <= err_bits_o;
                    total_bits_o <= total_bits_o;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/prbs_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module prbs_gen (
    input  wire logic                     clk_adc,
    input  wire logic                     reset_i,
    input  wire dcore_pkg::prbs_gen_cfg_t cfg_i,
    output logic                          bit_o
);

    logic [dcore_pkg::N_PRBS-1:0] state;
    logic                         new_bit;

    // fibonacci feedback, parity of tapped state bits
    assign new_bit = ^(state & cfg_i.eqn);

    //////////////////////////////////////////////////////////////////////
    // LFSR state and output
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            state <= cfg_i.init;
            bit_o <= 1'b0;
        end else if (cfg_i.cke) begin
            // new bit enters at the low end
            state <= {state[dcore_pkg::N_PRBS-2:0], new_bit};
            // injected error flips the output only
            bit_o <= new_bit ^ cfg_i.inj_err;
        end
    end

endmodule

`default_nettype wire

/* design/rx_bit_path.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_bit_path (
    input  wire logic                              clk_adc,
    input  wire logic                              reset_i,
    input  wire dcore_pkg::adc_codes_t             codes_i,
    input  wire logic signed [dcore_pkg::N_ADC-1:0] thresh_i,
    input  wire logic                              sel_bist_i,
    input  wire logic                              bist_bit_i,
    output dcore_pkg::rx_bits_t                    rx_bits_o
);

    dcore_pkg::rx_bits_t slice_bits;
    dcore_pkg::rx_bits_t bist_bits;

    //////////////////////////////////////////////////////////////////////
    // slicer
    //////////////////////////////////////////////////////////////////////

    // decide a one at or above the threshold, signed compare
    always_comb begin
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            slice_bits[k] = ($signed(codes_i[k]) >= thresh_i);
        end
    end

    // bist bit fans out to every channel
    assign bist_bits = {dcore_pkg::N_TI{bist_bit_i}};

    //////////////////////////////////////////////////////////////////////
    // source select and register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            rx_bits_o <= '0;
        end else if (sel_bist_i) begin
            rx_bits_o <= bist_bits;
        end else begin
            rx_bits_o <= slice_bits;
        end
    end

endmodule

`default_nettype wire

/* design/dcore_pkg.sv */
package dcore_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int N_TI     = 16;   // interleaved channels
    localparam int N_ADC    = 8;    // signed ADC code width
    localparam int N_PI     = 9;    // PI control code width
    localparam int N_OUT    = 4;    // PI outputs
    localparam int N_PRBS   = 32;   // LFSR state and tap mask width
    localparam int N_MAXSEL = 5;

    //////////////////////////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////////////////////////

    // one code per channel, each read back as signed
    typedef logic [N_TI-1:0][N_ADC-1:0] adc_codes_t;

    typedef logic [N_TI-1:0] rx_bits_t;

    typedef logic [N_OUT-1:0][N_PI-1:0] pi_codes_t;

    //////////////////////////////////////////////////////////////////////
    // configuration
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic              cke;
        logic [N_PRBS-1:0] eqn;
        logic [N_PRBS-1:0] init;
        logic              inj_err;
    } prbs_gen_cfg_t;

    // checker modes, encoding 2'd3 holds like freeze
    typedef enum logic [1:0] {
        CHK_ALIGN  = 2'd0,
        CHK_COUNT  = 2'd1,
        CHK_FREEZE = 2'd2
    } chk_mode_e;

    typedef struct packed {
        logic              cke;
        logic [N_PRBS-1:0] eqn;
        logic [N_TI-1:0]   chan_sel;
        chk_mode_e         mode;
    } prbs_chk_cfg_t;

    typedef struct packed {
        logic [N_MAXSEL-1:0] max_sel;
        logic [N_PI-1:0]     offset;
        logic                bypass_en;
        logic [N_PI-1:0]     bypass_code;
    } pi_ch_cfg_t;

endpackage
